// File: common/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Datapath and instruction word width
`define NBITS 32

// Instruction store depth in words
`define MEM_CELLS 64

// Word index width for the program load port
`define MEM_AW 6

// Architectural register count
`define REG_COUNT 32

// Register address width
`define REG_AW 5

`endif

// File: common/mips_pkg.sv
package mips_pkg;

    //////////////////////////////
    // Major opcodes
    //////////////////////////////

    // Bits 31..26 of every instruction
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_BEQ     = 6'b000100,
        OP_ADDI    = 6'b001000,
        OP_SLTI    = 6'b001010,
        OP_ORI     = 6'b001101,
        OP_HALT    = 6'b111111
    } opcode_e;

    // Function field of SPECIAL words
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010
    } funct_e;

    // ALU selector
    // Overflow is never trapped so ADD and ADDU share one op
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5,
        ALU_SLT = 4'd6,
        ALU_SLL = 4'd7
    } alu_op_e;

    //////////////////////////////
    // Instruction views
    //////////////////////////////

    // Register form
    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fields_t;

    // Immediate form also used by BEQ
    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // One fetched word whose opcode picks the meaningful view
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

endpackage

// File: fetch/instruction_memory.sv
`timescale 1ns/1ps
`include "mips_params.svh"

// Word-organized program store
// Combinational fetch, clocked load port
module instruction_memory
    import mips_pkg::*;
(
    input  logic                  i_clk,
    input  logic [`NBITS-1:0]     pc,
    output instr_u                instr,
    input  logic                  prog_we,
    input  logic [`MEM_AW-1:0]    prog_addr,
    input  logic [`NBITS-1:0]     prog_data
);

    // Program words
    logic [`NBITS-1:0] mem [`MEM_CELLS];

    // Byte PC divided by four
    logic [`NBITS-3:0] word_idx;
    logic              in_range;

    assign word_idx = pc[`NBITS-1:2];
    assign in_range = (word_idx < `MEM_CELLS);

    // Past the end reads as all zeros, which decodes as SLL r0 (no-op)
    assign instr = in_range ? mem[word_idx[`MEM_AW-1:0]] : '0;

    //////////////////////////////
    // Program load
    //////////////////////////////

    // Only driven while the core is stopped
    always_ff @(posedge i_clk)
    begin
        if (prog_we)
        begin
            mem[prog_addr] <= prog_data;
        end
    end

endmodule

// File: fetch/program_counter.sv
`timescale 1ns/1ps
`include "mips_params.svh"

// Byte-addressed PC and the sticky halt flag
module program_counter
(
    input  logic              i_clk,
    input  logic              rst_n,
    input  logic              run,
    input  logic              halt,
    input  logic              branch_taken,
    input  logic [`NBITS-1:0] branch_offset,
    output logic [`NBITS-1:0] pc,
    output logic              halted
);

    // Sequential successor
    logic [`NBITS-1:0] pc_seq;
    // Selected successor
    logic [`NBITS-1:0] pc_next;

    assign pc_seq = pc + 4;

    // Target is relative to the word after the branch
    assign pc_next = branch_taken ? (pc_seq + branch_offset) : pc_seq;

    //////////////////////////////
    // State update
    //////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (!rst_n)
        begin
            pc     <= '0;
            halted <= 1'b0;
        end
        else if (run && !halted)
        begin
            // PC parks on the halt word
            if (halt)
            begin
                halted <= 1'b1;
            end
            else
            begin
                pc <= pc_next;
            end
        end
    end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps
`include "mips_params.svh"

// Integer ALU
// All arithmetic wraps modulo 2^NBITS
module alu
    import mips_pkg::*;
(
    input  alu_op_e           alu_op,
    input  logic [`NBITS-1:0] a,
    input  logic [`NBITS-1:0] b,
    input  logic [4:0]        shamt,
    output logic [`NBITS-1:0] result,
    output logic              zero
);

    // Signed compare for SLT and SLTI
    logic a_lt_b;

    assign a_lt_b = ($signed(a) < $signed(b));

    always_comb
    begin
        case (alu_op)
            ALU_ADD:
                result = a + b;
            // Also used by BEQ
            ALU_SUB:
                result = a - b;
            ALU_AND:
                result = a & b;
            ALU_OR:
                result = a | b;
            ALU_XOR:
                result = a ^ b;
            ALU_NOR:
                result = ~(a | b);
            ALU_SLT:
                result = {{(`NBITS-1){1'b0}}, a_lt_b};
            // Shift operand comes from rt
            ALU_SLL:
                result = b << shamt;
            default:
                result = '0;
        endcase
    end

    //////////////////////////////
    // Flags
    //////////////////////////////

    // Equality test for branches
    assign zero = (result == '0);

endmodule

// File: logic/instruction_decoder.sv
`timescale 1ns/1ps
`include "mips_params.svh"

// Single-cycle control decode
// Opcode selects between the R and I views of the word
module instruction_decoder
    import mips_pkg::*;
(
    input  instr_u             instr,
    output logic [`REG_AW-1:0] rs_addr,
    output logic [`REG_AW-1:0] rt_addr,
    output logic [`REG_AW-1:0] wr_addr,
    output alu_op_e            alu_op,
    output logic               use_imm,
    output logic [`NBITS-1:0]  imm_value,
    output logic [4:0]         shamt,
    output logic               wr_en,
    output logic               is_branch,
    output logic               halt
);

    always_comb
    begin
        // Source fields sit at the same bits in both views
        rs_addr   = instr.r.rs;
        rt_addr   = instr.r.rt;
        // R-type writes rd
        wr_addr   = instr.r.rd;
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        // Sign extension by default
        imm_value = {{(`NBITS-16){instr.i.imm[15]}}, instr.i.imm};
        // Only SLL looks at the shift amount
        shamt     = instr.r.shamt;
        wr_en     = 1'b0;
        is_branch = 1'b0;
        halt      = 1'b0;

        case (instr.r.opcode)
            OP_SPECIAL:
            begin
                wr_en = 1'b1;
                case (instr.r.funct)
                    FN_SLL:          alu_op = ALU_SLL;
                    FN_ADD, FN_ADDU: alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:          alu_op = ALU_AND;
                    FN_OR:           alu_op = ALU_OR;
                    FN_XOR:          alu_op = ALU_XOR;
                    FN_NOR:          alu_op = ALU_NOR;
                    FN_SLT:          alu_op = ALU_SLT;
                    // Unknown function writes nothing
                    default:         wr_en  = 1'b0;
                endcase
            end
            OP_ADDI, OP_SLTI:
            begin
                wr_en   = 1'b1;
                use_imm = 1'b1;
                wr_addr = instr.i.rt;
                alu_op  = (instr.i.opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
            end
            OP_ORI:
            begin
                wr_en     = 1'b1;
                use_imm   = 1'b1;
                wr_addr   = instr.i.rt;
                alu_op    = ALU_OR;
                // Logical immediate is zero-extended
                imm_value = {{(`NBITS-16){1'b0}}, instr.i.imm};
            end
            OP_BEQ:
            begin
                // Compare rs with rt through the zero flag
                is_branch = 1'b1;
                alu_op    = ALU_SUB;
            end
            OP_HALT:
                halt = 1'b1;
            // Loads, stores and anything else fall through as no-op
            default:
                wr_en = 1'b0;
        endcase
    end

endmodule

// File: logic/mips_core.sv
`timescale 1ns/1ps
`include "mips_params.svh"

// Single-cycle core top
// Fetch, decode, read, execute and write back in one clock
module mips_core
    import mips_pkg::*;
(
    input  logic               i_clk,
    input  logic               rst_n,
    input  logic               run,
    input  logic               prog_we,
    input  logic [`MEM_AW-1:0] prog_addr,
    input  logic [`NBITS-1:0]  prog_data,
    output logic               halted,
    output logic               retire_valid,
    output logic [`NBITS-1:0]  retire_pc,
    output logic [`REG_AW-1:0] retire_rd,
    output logic [`NBITS-1:0]  retire_data
);

    //////////////////////////////
    // Internal nets
    //////////////////////////////

    logic [`NBITS-1:0]  pc;
    instr_u             instr;
    logic [`REG_AW-1:0] rs_addr;
    logic [`REG_AW-1:0] rt_addr;
    logic [`REG_AW-1:0] wr_addr;
    alu_op_e            alu_op;
    logic               use_imm;
    logic [`NBITS-1:0]  imm_value;
    logic [4:0]         shamt;
    logic               wr_en;
    logic               is_branch;
    logic               halt;
    logic [`NBITS-1:0]  rs_data;
    logic [`NBITS-1:0]  rt_data;
    logic [`NBITS-1:0]  alu_b;
    logic [`NBITS-1:0]  result;
    logic               zero;
    // Write actually committed this cycle
    logic               wr_commit;
    logic               branch_taken;
    logic [`NBITS-1:0]  branch_offset;

    // Second operand select
    assign alu_b = use_imm ? imm_value : rt_data;

    // Stopped or halted core neither writes nor retires
    assign wr_commit = wr_en & run & ~halted;

    // Word offset to byte offset
    assign branch_taken  = is_branch & zero;
    assign branch_offset = {imm_value[`NBITS-3:0], 2'b00};

    // Retire trace mirrors the write port
    assign retire_valid = wr_commit;
    assign retire_pc    = pc;
    assign retire_rd    = wr_addr;
    assign retire_data  = result;

    //////////////////////////////
    // Datapath blocks
    //////////////////////////////

    program_counter pc_i (
        .i_clk(i_clk), .rst_n(rst_n), .run(run), .halt(halt),
        .branch_taken(branch_taken), .branch_offset(branch_offset),
        .pc(pc), .halted(halted)
    );

    instruction_memory imem_i (
        .i_clk(i_clk), .pc(pc), .instr(instr),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data)
    );

    instruction_decoder dec_i (
        .instr(instr), .rs_addr(rs_addr), .rt_addr(rt_addr), .wr_addr(wr_addr),
        .alu_op(alu_op), .use_imm(use_imm), .imm_value(imm_value), .shamt(shamt),
        .wr_en(wr_en), .is_branch(is_branch), .halt(halt)
    );

    register_file rf_i (
        .i_clk(i_clk), .rst_n(rst_n), .rs_addr(rs_addr), .rt_addr(rt_addr),
        .rs_data(rs_data), .rt_data(rt_data),
        .wr_en(wr_commit), .wr_addr(wr_addr), .wr_data(result)
    );

    alu alu_i (
        .alu_op(alu_op), .a(rs_data), .b(alu_b), .shamt(shamt),
        .result(result), .zero(zero)
    );

endmodule

// File: logic/register_file.sv
`timescale 1ns/1ps
`include "mips_params.svh"

// General purpose registers
// Two combinational reads, one clocked write
module register_file
(
    input  logic               i_clk,
    input  logic               rst_n,
    input  logic [`REG_AW-1:0] rs_addr,
    input  logic [`REG_AW-1:0] rt_addr,
    output logic [`NBITS-1:0]  rs_data,
    output logic [`NBITS-1:0]  rt_data,
    input  logic               wr_en,
    input  logic [`REG_AW-1:0] wr_addr,
    input  logic [`NBITS-1:0]  wr_data
);

    logic [`NBITS-1:0] regs [`REG_COUNT];

    // Read ports
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (!rst_n)
        begin
            for (int k = 0; k < `REG_COUNT; k++)
            begin
                regs[k] <= '0;
            end
        end
        // r0 keeps its reset value of zero
        else if (wr_en && (wr_addr != '0))
        begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// File: mips_core.f
+incdir+common
common/mips_pkg.sv
fetch/instruction_memory.sv
fetch/program_counter.sv
logic/instruction_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/mips_core.sv
testbench/mips_core_tb.sv

// File: testbench/mips_core_tb.sv
`timescale 1ns/1ps
`include "mips_params.svh"

// Directed tests for the single-cycle core
// Expected retire trace comes from a behavioral model of the instruction set
module mips_core_tb
    import mips_pkg::*;
();

    logic               clk;
    logic               rst_n;
    logic               run;
    logic               prog_we;
    logic [`MEM_AW-1:0] prog_addr;
    logic [`NBITS-1:0]  prog_data;
    logic               halted;
    logic               retire_valid;
    logic [`NBITS-1:0]  retire_pc;
    logic [`REG_AW-1:0] retire_rd;
    logic [`NBITS-1:0]  retire_data;

    // Program image and the two retire traces
    logic [31:0] prog[$];
    logic [31:0] exp_pc[$], exp_rd[$], exp_data[$];
    logic [31:0] got_pc[$], got_rd[$], got_data[$];
    // Model register file
    logic [31:0] mregs [32];
    integer      seed = 3;

    mips_core dut_i (
        .i_clk(clk), .rst_n(rst_n), .run(run), .prog_we(prog_we),
        .prog_addr(prog_addr), .prog_data(prog_data), .halted(halted),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////
    // Encoders
    //////////////////////////////

    function automatic logic [31:0] r_word(input logic [4:0] rs, rt, rd, sh,
                                           input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs, rt,
                                           input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, actual, expected);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // Clears registers and drops run while memory keeps its contents
    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        run   <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        prog.delete();
    endtask

    task automatic load_word(input logic [`MEM_AW-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        prog_we   <= 1'b1;
        prog_addr <= addr;
        prog_data <= data;
        @(posedge clk);
        prog_we   <= 1'b0;
    endtask

    // Steps the model from pc 0 until the halt word
    task automatic model_program();
        logic [31:0] pc, w, a, b, se, res;
        logic [4:0]  dst;
        logic        wr;
        int          steps;
        for (int k = 0; k < 32; k++)
        begin
            mregs[k] = 32'h0;
        end
        exp_pc.delete();
        exp_rd.delete();
        exp_data.delete();
        pc    = 32'h0;
        steps = 0;
        while (steps < 200)
        begin
            w = ((pc >> 2) < prog.size()) ? prog[pc >> 2] : 32'h0;
            if (w[31:26] == OP_HALT)
                break;
            a   = mregs[w[25:21]];
            b   = mregs[w[20:16]];
            se  = {{16{w[15]}}, w[15:0]};
            wr  = 1'b1;
            dst = w[20:16];
            res = 32'h0;
            case (w[31:26])
                OP_SPECIAL:
                begin
                    dst = w[15:11];
                    case (w[5:0])
                        FN_SLL:          res = b << w[10:6];
                        FN_ADD, FN_ADDU: res = a + b;
                        FN_SUB, FN_SUBU: res = a - b;
                        FN_AND:          res = a & b;
                        FN_OR:           res = a | b;
                        FN_XOR:          res = a ^ b;
                        FN_NOR:          res = ~(a | b);
                        FN_SLT:          res = ($signed(a) < $signed(b)) ? 32'h1 : 32'h0;
                        default:         wr = 1'b0;
                    endcase
                end
                OP_ADDI: res = a + se;
                OP_ORI:  res = a | {16'h0, w[15:0]};
                OP_SLTI: res = ($signed(a) < $signed(se)) ? 32'h1 : 32'h0;
                OP_BEQ:
                begin
                    wr = 1'b0;
                    // Target is the next word plus the word offset
                    if (a == b)
                        pc = pc + (se << 2);
                end
                default: wr = 1'b0;
            endcase
            if (wr)
            begin
                exp_pc.push_back(pc);
                exp_rd.push_back({27'h0, dst});
                exp_data.push_back(res);
                if (dst != 5'd0)
                    mregs[dst] = res;
            end
            pc    = pc + 4;
            steps = steps + 1;
        end
    endtask

    // Loads the image, runs the core to halt and compares the traces
    task automatic run_program();
        int cycles;
        for (int k = 0; k < prog.size(); k++)
        begin
            load_word(k, prog[k]);
        end
        model_program();
        got_pc.delete();
        got_rd.delete();
        got_data.delete();
        @(posedge clk);
        run    <= 1'b1;
        cycles = 0;
        do
        begin
            // Trace is stable mid-cycle
            @(negedge clk);
            if (retire_valid === 1'b1)
            begin
                got_pc.push_back(retire_pc);
                got_rd.push_back({27'h0, retire_rd});
                got_data.push_back(retire_data);
            end
            cycles = cycles + 1;
            if (cycles > 500)
            begin
                $display("halt never reached");
                $display("test failed");
                $fatal(1);
            end
        end
        while (halted !== 1'b1);
        check_value("event_count", got_pc.size(), exp_pc.size());
        for (int k = 0; k < exp_pc.size(); k++)
        begin
            check_value("retire_pc", got_pc[k], exp_pc[k]);
            check_value("retire_rd", got_rd[k], exp_rd[k]);
            check_value("retire_data", got_data[k], exp_data[k]);
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset_state();
        apply_reset();
        // A writing instruction at pc 0 must not retire while run is low
        load_word(0, i_word(OP_ADDI, 0, 1, 16'h0001));
        @(negedge clk);
        check_value("retire_valid", retire_valid, 0);
        check_value("halted", halted, 0);
        check_value("retire_pc", retire_pc, 0);
    endtask

    task automatic test_alu_ops();
        apply_reset();
        for (int k = 1; k <= 4; k++)
        begin
            prog.push_back(i_word(OP_ADDI, 0, k, $random(seed)));
        end
        prog.push_back(r_word(1, 2, 5, 0, FN_ADD));
        prog.push_back(r_word(3, 4, 6, 0, FN_ADDU));
        prog.push_back(r_word(1, 3, 7, 0, FN_SUB));
        prog.push_back(r_word(2, 4, 8, 0, FN_SUBU));
        prog.push_back(r_word(1, 4, 9, 0, FN_AND));
        prog.push_back(r_word(2, 3, 10, 0, FN_OR));
        prog.push_back(r_word(1, 2, 11, 0, FN_XOR));
        prog.push_back(r_word(3, 4, 12, 0, FN_NOR));
        prog.push_back(r_word(1, 2, 13, 0, FN_SLT));
        prog.push_back(r_word(4, 3, 14, 0, FN_SLT));
        prog.push_back(32'hffff_ffff);
        run_program();
    endtask

    task automatic test_immediates();
        apply_reset();
        prog.push_back(i_word(OP_ADDI, 0, 1, 16'hfffb));
        prog.push_back(i_word(OP_ORI, 0, 2, 16'h8000));
        prog.push_back(i_word(OP_SLTI, 1, 3, 16'hfffd));
        prog.push_back(i_word(OP_SLTI, 2, 4, 16'h0005));
        prog.push_back(i_word(OP_ADDI, 1, 5, 16'h7fff));
        prog.push_back(32'hffff_ffff);
        run_program();
    endtask

    task automatic test_branches();
        apply_reset();
        prog.push_back(i_word(OP_ADDI, 0, 1, 7));
        prog.push_back(i_word(OP_ADDI, 0, 2, 7));
        // Taken branch skips the shadow word
        prog.push_back(i_word(OP_BEQ, 1, 2, 1));
        prog.push_back(i_word(OP_ADDI, 0, 3, 1));
        prog.push_back(i_word(OP_ADDI, 0, 4, 2));
        // Untaken branch falls through
        prog.push_back(i_word(OP_BEQ, 1, 3, 1));
        prog.push_back(i_word(OP_ADDI, 0, 5, 3));
        prog.push_back(32'hffff_ffff);
        run_program();
    endtask

    task automatic test_shift_and_r0();
        logic [4:0] sh;
        apply_reset();
        sh = $random(seed);
        prog.push_back(i_word(OP_ADDI, 0, 1, $random(seed)));
        prog.push_back(r_word(0, 1, 2, sh, FN_SLL));
        prog.push_back(i_word(OP_ADDI, 0, 0, 16'h007b));
        prog.push_back(r_word(0, 0, 3, 0, FN_ADD));
        prog.push_back(32'hffff_ffff);
        run_program();
    endtask

    task automatic test_halt();
        apply_reset();
        prog.push_back(i_word(OP_ADDI, 0, 1, 9));
        prog.push_back(32'hffff_ffff);
        prog.push_back(i_word(OP_ADDI, 0, 2, 5));
        run_program();
        // Run stays high while the PC stays parked on the halt word
        repeat (20)
        begin
            @(negedge clk);
            check_value("retire_valid", retire_valid, 0);
            check_value("halted", halted, 1);
            check_value("retire_pc", retire_pc, 32'h4);
        end
        // Parked word replaced by a writing instruction
        @(posedge clk);
        run <= 1'b0;
        load_word(1, i_word(OP_ADDI, 0, 6, 16'h0011));
        @(posedge clk);
        run <= 1'b1;
        // Halted core still retires nothing
        repeat (5)
        begin
            @(negedge clk);
            check_value("retire_valid", retire_valid, 0);
            check_value("halted", halted, 1);
            check_value("retire_pc", retire_pc, 32'h4);
        end
    endtask

    initial
    begin
        rst_n     = 1'b0;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        test_reset_state();
        test_alu_ops();
        test_immediates();
        test_branches();
        test_shift_and_r0();
        test_halt();
        $display("test passed");
        $finish;
    end

endmodule
